//--- rat_checker.sv
`timescale 1ns/1ps

module rat_checker #(
  parameter int NUM_ARCH  = 16,
  parameter int NUM_LANES = 3
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                read_en,
  input  rat_pkg::rename_wr_t [NUM_LANES-1:0] rename_wr,
  input  rat_pkg::retire_wr_t [NUM_LANES-1:0] retire_wr,
  input  logic                                retire_all,
  input  rat_pkg::read_req_t  [NUM_LANES-1:0] read_req,
  input  rat_pkg::read_rsp_t  [NUM_LANES-1:0] read_rsp,
  output int                                  error_count,
  output int                                  compare_count
);

  rat_pkg::map_entry_t m_entry [NUM_ARCH];
  logic                m_ret   [NUM_ARCH];
  rat_pkg::domain_t    m_pend  [NUM_ARCH];
  rat_pkg::read_req_t  m_req   [NUM_LANES];
  rat_pkg::map_entry_t m_lane  [NUM_LANES][NUM_LANES];
  logic                seen_read = 1'b0;
  int                  errs = 0;
  int                  checks = 0;

  assign error_count   = errs;
  assign compare_count = checks;

  // expected response of one read lane from the model
  function automatic rat_pkg::read_rsp_t expected_rsp(input int p);
    rat_pkg::read_rsp_t r;
    r = '0;
    if (m_req[p].dep)
    begin
      if (int'(m_req[p].lane) < NUM_LANES)
      begin
        r.data = m_lane[p][m_req[p].lane];
      end
      r.is_dep = 1'b1;
    end
    else
    begin
      r.data    = m_entry[m_req[p].arch];
      r.retired = m_ret[m_req[p].arch];
    end
    return r;
  endfunction

  // table model, sees the pre-edge inputs just like the flops
  always @(posedge clk)
  begin
    rat_pkg::map_entry_t nd;
    logic                hit;
    logic                thit;
    if (rst)
    begin
      for (int a = 0; a < NUM_ARCH; a++)
      begin
        m_entry[a] = '{tag: '0, funit: rat_pkg::FUNIT_RESET, dom: '0};
        m_ret[a]   = 1'b1;
        m_pend[a]  = '0;
      end
      for (int p = 0; p < NUM_LANES; p++)
      begin
        m_req[p] = '0;
      end
      seen_read = 1'b0;
    end
    else
    begin
      for (int a = 0; a < NUM_ARCH; a++)
      begin
        hit  = 1'b0;
        thit = 1'b0;
        nd   = m_entry[a];
        for (int l = 0; l < NUM_LANES; l++)
        begin
          if (read_en && rename_wr[l].wen && rename_wr[l].arch == rat_pkg::arch_addr_t'(a))
          begin
            hit = 1'b1;
            nd  = rename_wr[l].data;
          end
          if (retire_wr[l].wen && retire_wr[l].tag == m_entry[a].tag)
          begin
            thit = 1'b1;
          end
        end
        // committed domain is the pending one from before this edge
        if (retire_all)
        begin
          nd.dom = m_pend[a];
        end
        for (int l = 0; l < NUM_LANES; l++)
        begin
          if (retire_wr[l].wen && retire_wr[l].arch == rat_pkg::arch_addr_t'(a))
          begin
            m_pend[a] = retire_wr[l].dom;
          end
        end
        m_ret[a]   = retire_all || (!hit && (thit || m_ret[a]));
        m_entry[a] = nd;
      end
      for (int p = 0; p < NUM_LANES; p++)
      begin
        if (read_en)
        begin
          m_req[p] = read_req[p];
          if (read_req[p].dep)
          begin
            for (int l = 0; l < NUM_LANES; l++)
            begin
              m_lane[p][l] = rename_wr[l].data;
            end
          end
        end
      end
      if (read_en)
      begin
        seen_read = 1'b1;
      end
    end
  end

  // responses are settled by the falling edge
  always @(negedge clk)
  begin
    rat_pkg::read_rsp_t exp_rsp;
    if (!rst && seen_read)
    begin
      for (int p = 0; p < NUM_LANES; p++)
      begin
        exp_rsp = expected_rsp(p);
        checks++;
        if (read_rsp[p] !== exp_rsp)
        begin
          errs++;
          $display("mismatch at %0t: read_rsp[%0d] expected %h, got %h",
                   $time, p, exp_rsp, read_rsp[p]);
        end
      end
    end
  end

endmodule

//--- rat_entry.sv
`timescale 1ns/1ps

module rat_entry #(
  parameter int INDEX     = 0,
  parameter int NUM_LANES = 3
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                read_en,
  input  rat_pkg::rename_wr_t [NUM_LANES-1:0] rename_wr,
  input  rat_pkg::retire_wr_t [NUM_LANES-1:0] retire_wr,
  input  logic                                retire_all,
  output rat_pkg::map_entry_t                 entry,
  output logic                                retired
);

  localparam rat_pkg::arch_addr_t SELF = rat_pkg::arch_addr_t'(INDEX);

  rat_pkg::map_entry_t entry_q;
  rat_pkg::domain_t    dom_pend_q;
  logic                retired_q;

  logic                new_hit;
  rat_pkg::map_entry_t new_data;
  logic                tag_hit;
  logic                pend_hit;
  rat_pkg::domain_t    pend_dom;

  // rename decode, later lanes overwrite earlier ones so the highest lane wins
  always_comb
  begin
    new_hit  = 1'b0;
    new_data = entry_q;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      if (read_en && rename_wr[l].wen && rename_wr[l].arch == SELF)
      begin
        new_hit  = 1'b1;
        new_data = rename_wr[l].data;
      end
    end
  end

  // retire side: tag compare against the stored tag and pending domain decode
  always_comb
  begin
    tag_hit  = 1'b0;
    pend_hit = 1'b0;
    pend_dom = dom_pend_q;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      if (retire_wr[l].wen && retire_wr[l].tag == entry_q.tag)
      begin
        tag_hit = 1'b1;
      end
      if (retire_wr[l].wen && retire_wr[l].arch == SELF)
      begin
        pend_hit = 1'b1;
        pend_dom = retire_wr[l].dom;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      entry_q    <= rat_pkg::ENTRY_RESET;
      dom_pend_q <= '0;
      retired_q  <= 1'b1;
    end
    else
    begin
      if (new_hit)
      begin
        entry_q.tag   <= new_data.tag;
        entry_q.funit <= new_data.funit;
      end
      // the committed domain wins over a renamed one
      if (retire_all)
      begin
        entry_q.dom <= dom_pend_q;
      end
      else if (new_hit)
      begin
        entry_q.dom <= new_data.dom;
      end
      // a tag match only counts when no new mapping lands this cycle
      if (retire_all || (tag_hit && !new_hit))
      begin
        retired_q <= 1'b1;
      end
      else if (new_hit)
      begin
        retired_q <= 1'b0;
      end
      if (pend_hit)
      begin
        dom_pend_q <= pend_dom;
      end
    end
  end

  assign entry   = entry_q;
  assign retired = retired_q;

endmodule

//--- rat_pkg.sv
package rat_pkg;

  localparam int TAG_W   = 9;
  localparam int FUNIT_W = 10;
  localparam int DOM_W   = 2;
  localparam int ARCH_W  = 4;
  localparam int LANE_W  = 2;

  typedef logic [TAG_W-1:0]   rob_tag_t;
  typedef logic [FUNIT_W-1:0] funit_t;
  typedef logic [DOM_W-1:0]   domain_t;
  typedef logic [ARCH_W-1:0]  arch_addr_t;
  typedef logic [LANE_W-1:0]  lane_idx_t;

  // only the top bit set, no unit owns the register yet
  localparam funit_t FUNIT_RESET = {1'b1, {(FUNIT_W-1){1'b0}}};

  // one map entry, also the payload of a rename write
  typedef struct packed {
    rob_tag_t tag;
    funit_t   funit;
    domain_t  dom;
  } map_entry_t;

  localparam map_entry_t ENTRY_RESET = '{tag: '0, funit: FUNIT_RESET, dom: '0};

  typedef struct packed {
    logic       wen;
    arch_addr_t arch;
    map_entry_t data;
  } rename_wr_t;

  // tag retires by match, arch and dom load the pending domain
  typedef struct packed {
    logic       wen;
    rob_tag_t   tag;
    arch_addr_t arch;
    domain_t    dom;
  } retire_wr_t;

  // dep set means lane names a lane of the same rename group
  typedef struct packed {
    logic       dep;
    arch_addr_t arch;
    lane_idx_t  lane;
  } read_req_t;

  typedef struct packed {
    map_entry_t data;
    logic       retired;
    logic       is_dep;
  } read_rsp_t;

endpackage

//--- rat_props.sv
`timescale 1ns/1ps

module rat_props #(
  parameter int NUM_LANES = 3
) (
  input logic                                clk,
  input logic                                rst,
  input logic                                read_en,
  input rat_pkg::read_req_t                  req,
  input rat_pkg::read_rsp_t                  rsp,
  input rat_pkg::rename_wr_t [NUM_LANES-1:0] lane_new
);

  int                   fail_count = 0;
  logic                 renamed;
  logic                 dep_held;
  logic [NUM_LANES-1:0] new_wen;

  always_comb
  begin
    for (int l = 0; l < NUM_LANES; l++)
    begin
      new_wen[l] = lane_new[l].wen;
    end
  end

  // set once any rename write has landed since reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      renamed <= 1'b0;
    end
    else if (read_en && |new_wen)
    begin
      renamed <= 1'b1;
    end
  end

  // a dep request accepted on the last read_en edge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      dep_held <= 1'b0;
    end
    else if (read_en)
    begin
      dep_held <= req.dep;
    end
  end

  dep_not_retired: assert property (@(posedge clk) disable iff (rst)
    dep_held |-> !rsp.retired)
  else
  begin
    fail_count++;
    $error("dependency response is flagged retired");
  end

  dep_req_flagged: assert property (@(posedge clk) disable iff (rst)
    dep_held |-> rsp.is_dep)
  else
  begin
    fail_count++;
    $error("registered dependency request without is_dep");
  end

  // nothing can clear retired before the first rename
  retired_before_rename: assert property (@(posedge clk) disable iff (rst)
    (!renamed && !dep_held) |-> rsp.retired)
  else
  begin
    fail_count++;
    $error("entry reads as not retired before any rename write");
  end

endmodule

bind rat_read_port rat_props #(
  .NUM_LANES (NUM_LANES)
) rat_props_i (
  .clk      (clk),
  .rst      (rst),
  .read_en  (read_en),
  .req      (req),
  .rsp      (rsp),
  .lane_new (lane_new)
);

//--- rat_read_port.sv
`timescale 1ns/1ps

module rat_read_port #(
  parameter int NUM_ARCH  = 16,
  parameter int NUM_LANES = 3
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                read_en,
  input  rat_pkg::read_req_t                  req,
  input  rat_pkg::map_entry_t [NUM_ARCH-1:0]  entries,
  input  logic                [NUM_ARCH-1:0]  retired,
  input  rat_pkg::rename_wr_t [NUM_LANES-1:0] lane_new,
  output rat_pkg::read_rsp_t                  rsp
);

  rat_pkg::read_req_t                  req_q;
  rat_pkg::map_entry_t [NUM_LANES-1:0] lane_q;

  rat_pkg::map_entry_t ent_sel;
  logic                ret_sel;
  rat_pkg::map_entry_t dep_sel;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      req_q <= '0;
    end
    else if (read_en)
    begin
      req_q <= req;
    end
  end

  // snapshot of the rename group payloads taken with a dep request
  always_ff @(posedge clk)
  begin
    if (read_en && req.dep)
    begin
      for (int l = 0; l < NUM_LANES; l++)
      begin
        lane_q[l] <= lane_new[l].data;
      end
    end
  end

  // live entry, so writes at the request edge are already visible
  always_comb
  begin
    ent_sel = '0;
    ret_sel = 1'b0;
    for (int a = 0; a < NUM_ARCH; a++)
    begin
      if (req_q.arch == rat_pkg::arch_addr_t'(a))
      begin
        ent_sel = entries[a];
        ret_sel = retired[a];
      end
    end
  end

  // lane numbers past NUM_LANES read as zero
  always_comb
  begin
    dep_sel = '0;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      if (req_q.lane == rat_pkg::lane_idx_t'(l))
      begin
        dep_sel = lane_q[l];
      end
    end
  end

  assign rsp.data    = req_q.dep ? dep_sel : ent_sel;
  assign rsp.retired = !req_q.dep && ret_sel;
  assign rsp.is_dep  = req_q.dep;

endmodule

//--- rat_top.sv
`timescale 1ns/1ps

module rat_top #(
  parameter int NUM_ARCH  = 16,
  parameter int NUM_LANES = 3
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                read_en,
  input  rat_pkg::rename_wr_t [NUM_LANES-1:0] rename_wr,
  input  rat_pkg::retire_wr_t [NUM_LANES-1:0] retire_wr,
  input  logic                                retire_all,
  input  rat_pkg::read_req_t  [NUM_LANES-1:0] read_req,
  output rat_pkg::read_rsp_t  [NUM_LANES-1:0] read_rsp
);

  // whole table, fanned out to every read port
  rat_pkg::map_entry_t [NUM_ARCH-1:0] entry_q;
  logic                [NUM_ARCH-1:0] entry_ret;

  genvar gi;

  // one map entry per architectural vector register
  for (gi = 0; gi < NUM_ARCH; gi++)
  begin : g_entry
    rat_entry #(
      .INDEX     (gi),
      .NUM_LANES (NUM_LANES)
    ) rat_entry_i (
      .clk        (clk),
      .rst        (rst),
      .read_en    (read_en),
      .rename_wr  (rename_wr),
      .retire_wr  (retire_wr),
      .retire_all (retire_all),
      .entry      (entry_q[gi]),
      .retired    (entry_ret[gi])
    );
  end

  // one read port per lane, each sees the new payloads of the whole group
  for (gi = 0; gi < NUM_LANES; gi++)
  begin : g_read
    rat_read_port #(
      .NUM_ARCH  (NUM_ARCH),
      .NUM_LANES (NUM_LANES)
    ) rat_read_port_i (
      .clk      (clk),
      .rst      (rst),
      .read_en  (read_en),
      .req      (read_req[gi]),
      .entries  (entry_q),
      .retired  (entry_ret),
      .lane_new (rename_wr),
      .rsp      (read_rsp[gi])
    );
  end

endmodule

//--- tb_rat.sv
`timescale 1ns/1ps

module tb_rat;

  localparam int NUM_ARCH  = 16;
  localparam int NUM_LANES = 3;

  logic                                clk;
  logic                                rst;
  logic                                read_en;
  logic                                retire_all;
  rat_pkg::rename_wr_t [NUM_LANES-1:0] rename_wr;
  rat_pkg::retire_wr_t [NUM_LANES-1:0] retire_wr;
  rat_pkg::read_req_t  [NUM_LANES-1:0] read_req;
  rat_pkg::read_rsp_t  [NUM_LANES-1:0] read_rsp;

  int seed = 25948;
  int error_count;
  int compare_count;
  int timeouts = 0;
  int prop_fails;

  rat_top #(
    .NUM_ARCH  (NUM_ARCH),
    .NUM_LANES (NUM_LANES)
  ) rat_top_i (
    .clk        (clk),
    .rst        (rst),
    .read_en    (read_en),
    .rename_wr  (rename_wr),
    .retire_wr  (retire_wr),
    .retire_all (retire_all),
    .read_req   (read_req),
    .read_rsp   (read_rsp)
  );

  rat_checker #(
    .NUM_ARCH  (NUM_ARCH),
    .NUM_LANES (NUM_LANES)
  ) rat_checker_i (
    .clk           (clk),
    .rst           (rst),
    .read_en       (read_en),
    .rename_wr     (rename_wr),
    .retire_wr     (retire_wr),
    .retire_all    (retire_all),
    .read_req      (read_req),
    .read_rsp      (read_rsp),
    .error_count   (error_count),
    .compare_count (compare_count)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #4 clk = ~clk;
    end
  end

  function automatic int pick(input int range);
    return $unsigned($random(seed)) % range;
  endfunction

  task automatic idle_inputs();
    read_en    <= 1'b0;
    retire_all <= 1'b0;
    rename_wr  <= '0;
    retire_wr  <= '0;
    read_req   <= '0;
  endtask

  task automatic rename_lane(input int l, input int arch, input int tag);
    rename_wr[l].wen        <= 1'b1;
    rename_wr[l].arch       <= rat_pkg::arch_addr_t'(arch);
    rename_wr[l].data.tag   <= rat_pkg::rob_tag_t'(tag);
    rename_wr[l].data.funit <= rat_pkg::funit_t'(tag * 37 + l);
    rename_wr[l].data.dom   <= rat_pkg::domain_t'(tag + l);
  endtask

  // small tag range keeps retire matches frequent
  task automatic random_cycle(input int read_pct);
    @(posedge clk);
    read_en    <= (pick(100) < read_pct);
    retire_all <= (pick(16) == 0);
    for (int l = 0; l < NUM_LANES; l++)
    begin
      rename_wr[l].wen        <= (pick(2) == 1);
      rename_wr[l].arch       <= rat_pkg::arch_addr_t'(pick(NUM_ARCH));
      rename_wr[l].data.tag   <= rat_pkg::rob_tag_t'(pick(4));
      rename_wr[l].data.funit <= rat_pkg::funit_t'(pick(1024));
      rename_wr[l].data.dom   <= rat_pkg::domain_t'(pick(4));
      retire_wr[l].wen        <= (pick(2) == 1);
      retire_wr[l].tag        <= rat_pkg::rob_tag_t'(pick(4));
      retire_wr[l].arch       <= rat_pkg::arch_addr_t'(pick(NUM_ARCH));
      retire_wr[l].dom        <= rat_pkg::domain_t'(pick(4));
      read_req[l].dep         <= (pick(4) == 0);
      read_req[l].arch        <= rat_pkg::arch_addr_t'(pick(NUM_ARCH));
      read_req[l].lane        <= rat_pkg::lane_idx_t'(pick(NUM_LANES));
    end
  endtask

  task automatic wait_compares(input int target, input int limit);
    int n;
    n = 0;
    while (compare_count < target && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    if (compare_count < target)
    begin
      $display("timeout: checker made only %0d of %0d compares", compare_count, target);
      timeouts++;
    end
  endtask

  initial
  begin
    int start;
    rst        = 1'b1;
    read_en    = 1'b0;
    retire_all = 1'b0;
    rename_wr  = '0;
    retire_wr  = '0;
    read_req   = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // every register straight out of reset
    for (int base = 0; base < NUM_ARCH; base += NUM_LANES)
    begin
      @(posedge clk);
      idle_inputs();
      read_en <= 1'b1;
      for (int l = 0; l < NUM_LANES; l++)
      begin
        read_req[l].arch <= rat_pkg::arch_addr_t'((base + l) % NUM_ARCH);
      end
    end
    wait_compares(NUM_LANES * 4, 20);
    // three lanes rename register 5, then a write that must not land
    @(posedge clk);
    idle_inputs();
    read_en          <= 1'b1;
    read_req[0].arch <= 4'd5;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      rename_lane(l, 5, l + 1);
    end
    @(posedge clk);
    idle_inputs();
    rename_lane(0, 5, 9);
    // dep reads, payloads change afterwards while read_en is low
    @(posedge clk);
    idle_inputs();
    read_en <= 1'b1;
    for (int l = 0; l < NUM_LANES; l++)
    begin
      rename_lane(l, l + 8, l + 1);
      read_req[l].dep  <= 1'b1;
      read_req[l].lane <= rat_pkg::lane_idx_t'(NUM_LANES - 1 - l);
    end
    repeat (4)
    begin
      @(posedge clk);
      idle_inputs();
      for (int l = 0; l < NUM_LANES; l++)
      begin
        rename_lane(l, l, pick(4));
      end
    end
    for (int i = 0; i < 600; i++)
    begin
      random_cycle(60);
    end
    @(posedge clk);
    idle_inputs();
    start = compare_count;
    wait_compares(start + NUM_LANES * 4, 20);
    prop_fails = rat_top_i.g_read[0].rat_read_port_i.rat_props_i.fail_count
               + rat_top_i.g_read[1].rat_read_port_i.rat_props_i.fail_count
               + rat_top_i.g_read[2].rat_read_port_i.rat_props_i.fail_count;
    $display("compares %0d, mismatches %0d, assertion failures %0d, timeouts %0d",
             compare_count, error_count, prop_fails, timeouts);
    if (error_count == 0 && prop_fails == 0 && timeouts == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
rat_pkg.sv
rat_entry.sv
rat_read_port.sv
rat_top.sv
rat_props.sv
rat_checker.sv
tb_rat.sv
